/* sdram_ctrl_top.f */
sdram_cmd_pkg.sv
ctrl_cfg_pkg.sv
request_framer.sv
request_fifo.sv
command_sequencer.sv
initializer.sv
sdram_ctrl_top.sv
tb_clock.sv
sdram_ctrl_chk.sv
sdram_ctrl_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the sdram_ctrl_top testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module sdram_ctrl_tb -f sdram_ctrl_top.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build did not succeed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
	echo "simulation ended without a pass line"
	exit 1
fi
exit 0

/* sdram_ctrl_tb.sv */
`timescale 1ns/1ps

module sdram_ctrl_tb
	import sdram_cmd_pkg::*;
	import ctrl_cfg_pkg::*;
();

	logic      CLK_n;
	logic      RST;
	logic      req_rd;
	logic      req_wr;
	req_addr_t req_addr;
	logic      busy;
	logic      ready;
	logic      cke;
	cmd_t      command_pin;
	addr_t     address_pin;
	bank_t     bank_pin;

	req_t        exp_q[$];         // requests issued, not yet seen on the pins
	req_t        cur;
	logic [31:0] rng;
	int          n_sent = 0;
	int          n_actv = 0;
	int          n_prch = 0;
	int          phase = 0;        // 0 activate, 1 access, 2 precharge
	int          cyc = 0;
	int          t_act = 0;
	int          t_acc = 0;
	logic        busy_q = 1'b0;    // busy as seen at the falling edge
	logic        burst_on = 1'b0;
	logic        busy_seen = 1'b0;

	tb_clock tb_clock_i (
		.CLK_n (CLK_n),
		.RST   (RST)
	);

	sdram_ctrl_top sdram_ctrl_top_i (
		.CLK_n       (CLK_n),
		.RST         (RST),
		.req_rd      (req_rd),
		.req_wr      (req_wr),
		.req_addr    (req_addr),
		.busy        (busy),
		.ready       (ready),
		.cke         (cke),
		.command_pin (command_pin),
		.address_pin (address_pin),
		.bank_pin    (bank_pin)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// command, address, bank of each init step
	function automatic logic [17:0] init_step(input int k);
		case (k)
			0:       return {PRCH, 13'h200, 2'd1};
			1:       return {MRST, 13'h000, 2'd1};
			2:       return {MRST, 13'h131, 2'd0};
			3:       return {PRCH, 13'h200, 2'd0};
			4:       return {ARSR, 13'h200, 2'd0};
			5:       return {ARSR, 13'h200, 2'd0};
			default: return {MRST, 13'h031, 2'd0};
		endcase
	endfunction

	task automatic give_up(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			give_up($sformatf("ERROR %s expected %0h actual %0h", name, expected, actual));
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge CLK_n);
			req_rd <= 1'b0;
			req_wr <= 1'b0;
		end
	endtask

	// waits for room while counting requests still in flight
	task automatic send_request();
		int          n;
		logic [31:0] r;
		logic        wr;
		n = 0;
		@(posedge CLK_n);
		while (busy_q || (n_sent - n_actv) >= FIFO_DEPTH)
		begin
			req_rd <= 1'b0;
			req_wr <= 1'b0;
			@(posedge CLK_n);
			n++;
			if (n > 100)
				give_up("timeout waiting for room in the request buffer");
		end
		rng = xorshift(rng);
		r = rng;
		wr = (r[25:24] == 2'b01) || (r[25:24] == 2'b10);    // 2'b10 drives both strobes
		req_addr <= r[23:0];
		req_rd   <= (r[25:24] != 2'b01);
		req_wr   <= wr;
		exp_q.push_back({wr, r[23:0]});
		n_sent++;
	endtask

	task automatic match_command();
		case (phase)
			0:
			begin
				if (exp_q.size() == 0)
					give_up("activate seen with no request pending");
				cur = exp_q.pop_front();
				check("activate cmd", 32'(ACTV), 32'(command_pin));
				check("activate bank", 32'(cur[23:22]), 32'(bank_pin));
				check("activate row", 32'(cur[21:9]), 32'(address_pin));
				if (n_actv > 0 && (cyc - t_act) < 10)
					give_up("two activates closer than 10 cycles");
				t_act = cyc;
				n_actv++;
				phase = 1;
			end
			1:
			begin
				check("access cmd", 32'(cur[24] ? WRIT : READ), 32'(command_pin));
				check("access bank", 32'(cur[23:22]), 32'(bank_pin));
				check("access column", 32'(cur[8:0]), 32'(address_pin));
				check("access spacing", T_RCD + 1, cyc - t_act);
				t_acc = cyc;
				phase = 2;
			end
			default:
			begin
				check("precharge cmd", 32'(PRCH), 32'(command_pin));
				check("precharge bank", 32'(cur[23:22]), 32'(bank_pin));
				check("precharge a10", 0, 32'(address_pin[10]));
				check("precharge spacing", T_ACC + 1, cyc - t_acc);
				n_prch++;
				phase = 0;
			end
		endcase
	endtask

	// pin monitor samples at the falling edge where pins are stable
	always @(negedge CLK_n)
	begin
		cyc++;
		busy_q = busy;
		if (burst_on && busy)
			busy_seen = 1'b1;
		if (ready === 1'b1 && command_pin !== NOOP)
			match_command();
	end

	initial
	begin
		int          n;
		int          k;
		logic [17:0] step;
		req_rd   <= 1'b0;
		req_wr   <= 1'b0;
		req_addr <= '0;
		rng      = 32'haf7f_f46e;

		n = 0;
		while (RST !== 1'b1)
		begin
			@(negedge CLK_n);
			n++;
			if (n > 10)
				give_up("reset was never released");
		end

		n = 0;
		while (cke !== 1'b1)
		begin
			check("power-up cmd", 32'(NOOP), 32'(command_pin));
			check("power-up ready", 0, 32'(ready));
			@(negedge CLK_n);
			n++;
			if (n > POWER_UP_CYCLES + 10)
				give_up("timeout waiting for cke");
		end
		check("cke delay", POWER_UP_CYCLES, n);

		for (k = 0; k < 7; k++)
		begin
			n = 0;
			do
			begin
				@(negedge CLK_n);
				n++;
				if (n > STEP_GAP + 10)
					give_up("timeout waiting for an init command");
			end
			while (command_pin === NOOP);
			step = init_step(k);
			check("init gap", STEP_GAP, n);
			check("init cmd", 32'(step[17:15]), 32'(command_pin));
			check("init address", 32'(step[14:2]), 32'(address_pin));
			check("init bank", 32'(step[1:0]), 32'(bank_pin));
		end

		n = 0;
		while (ready !== 1'b1)
		begin
			@(negedge CLK_n);
			n++;
			check("settle cmd", 32'(NOOP), 32'(command_pin));
			if (n > SETTLE_CYCLES + 10)
				give_up("timeout waiting for ready");
		end
		check("ready delay", SETTLE_CYCLES, n);

		for (k = 0; k < 200; k++)
		begin
			rng = xorshift(rng);
			idle_cycles(int'(rng % 13));
			send_request();
		end

		burst_on = 1'b1;
		for (k = 0; k < 16; k++)
			send_request();
		idle_cycles(1);

		n = 0;
		while (n_prch < n_sent)
		begin
			@(posedge CLK_n);
			n++;
			if (n > 400)
				give_up("timeout waiting for the requests to drain");
		end
		burst_on = 1'b0;

		check("busy during burst", 1, 32'(busy_seen));
		$display(">>> PASS");
		$finish;
	end

endmodule

/* sdram_ctrl_chk.sv */
`timescale 1ns/1ps

module sdram_ctrl_chk
	import sdram_cmd_pkg::*;
(
	input logic CLK_n,
	input logic RST,
	input logic push,
	input logic busy,
	input logic cke,
	input logic ready,
	input cmd_t command_pin
);

	// the buffer drops such a push, so the request is lost
	no_push_when_full: assert property (@(posedge CLK_n) disable iff (!RST)
		!(push && busy))
		else $error("push while the request buffer is full");

	noop_while_cke_low: assert property (@(posedge CLK_n) disable iff (!RST)
		!cke |-> command_pin == NOOP)
		else $error("command issued while cke is low");

	ready_stays_high: assert property (@(posedge CLK_n) disable iff (!RST)
		ready |=> ready)
		else $error("ready fell after init");

endmodule

bind sdram_ctrl_top sdram_ctrl_chk sdram_ctrl_chk_i (
	.CLK_n       (CLK_n),
	.RST         (RST),
	.push        (push),
	.busy        (busy),
	.cke         (cke),
	.ready       (ready),
	.command_pin (command_pin)
);

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock
(
	output logic CLK_n,
	output logic RST
);

	initial
	begin
		CLK_n = 1'b0;
		forever #10 CLK_n = ~CLK_n;    // 20 ns period
	end

	initial
	begin
		RST = 1'b0;
		repeat (3) @(posedge CLK_n);
		RST <= 1'b1;    // released on the third rising edge
	end

endmodule

/* sdram_ctrl_top.sv */
`timescale 1ns/1ps

module sdram_ctrl_top
	import sdram_cmd_pkg::*;
	import ctrl_cfg_pkg::*;
(
	input  logic      CLK_n,
	input  logic      RST,
	input  logic      req_rd,
	input  logic      req_wr,
	input  req_addr_t req_addr,
	output logic      busy,
	output logic      ready,
	output logic      cke,
	output cmd_t      command_pin,
	output addr_t     address_pin,
	output bank_t     bank_pin
);

	logic  push;
	req_t  push_data;
	logic  pop;
	req_t  pop_data;
	logic  empty;
	cmd_t  seq_cmd;
	addr_t seq_addr;
	bank_t seq_bank;

	request_framer request_framer_i (
		.CLK_n     (CLK_n),
		.RST       (RST),
		.req_rd    (req_rd),
		.req_wr    (req_wr),
		.req_addr  (req_addr),
		.push      (push),
		.push_data (push_data)
	);

	request_fifo request_fifo_i (
		.CLK_n     (CLK_n),
		.RST       (RST),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.pop_data  (pop_data),
		.full      (busy),        // user holds off while full
		.empty     (empty)
	);

	command_sequencer command_sequencer_i (
		.CLK_n    (CLK_n),
		.RST      (RST),
		.ready    (ready),
		.empty    (empty),
		.pop_data (pop_data),
		.pop      (pop),
		.seq_cmd  (seq_cmd),
		.seq_addr (seq_addr),
		.seq_bank (seq_bank)
	);

	initializer initializer_i (
		.CLK_n       (CLK_n),
		.RST         (RST),
		.seq_cmd     (seq_cmd),
		.seq_addr    (seq_addr),
		.seq_bank    (seq_bank),
		.cke         (cke),
		.ready       (ready),
		.command_pin (command_pin),
		.address_pin (address_pin),
		.bank_pin    (bank_pin)
	);

endmodule

/* initializer.sv */
`timescale 1ns/1ps

module initializer
	import sdram_cmd_pkg::*;
	import ctrl_cfg_pkg::*;
(
	input  logic  CLK_n,
	input  logic  RST,
	input  cmd_t  seq_cmd,
	input  addr_t seq_addr,
	input  bank_t seq_bank,
	output logic  cke,
	output logic  ready,
	output cmd_t  command_pin,
	output addr_t address_pin,
	output bank_t bank_pin
);

	logic [15:0] pwr_cnt;
	logic [3:0]  step_cnt;
	logic [2:0]  stage;
	logic [7:0]  settle_cnt;
	logic        step_due;
	logic        list_done;

	cmd_t  ini_cmd;
	addr_t ini_addr;
	bank_t ini_bank;
	cmd_t  rom_cmd;
	addr_t rom_addr;
	bank_t rom_bank;

	assign step_due  = (step_cnt == 4'(STEP_GAP - 1));
	assign list_done = (rom_cmd == NOOP);    // stopped by the terminator

	// zero latency mux, sequencer owns the pins once ready
	assign command_pin = ready ? seq_cmd  : ini_cmd;
	assign address_pin = ready ? seq_addr : ini_addr;
	assign bank_pin    = ready ? seq_bank : ini_bank;

	always_comb
	begin
		case (stage)
			3'd0:    begin rom_cmd = PRCH; rom_addr = 13'h200; rom_bank = 2'd1; end
			3'd1:    begin rom_cmd = MRST; rom_addr = 13'h000; rom_bank = 2'd1; end  // ext mode
			3'd2:    begin rom_cmd = MRST; rom_addr = 13'h131; rom_bank = 2'd0; end  // dll reset
			3'd3:    begin rom_cmd = PRCH; rom_addr = 13'h200; rom_bank = 2'd0; end
			3'd4:    begin rom_cmd = ARSR; rom_addr = 13'h200; rom_bank = 2'd0; end
			3'd5:    begin rom_cmd = ARSR; rom_addr = 13'h200; rom_bank = 2'd0; end
			3'd6:    begin rom_cmd = MRST; rom_addr = 13'h031; rom_bank = 2'd0; end  // final mode
			default: begin rom_cmd = NOOP; rom_addr = 13'h200; rom_bank = 2'd0; end
		endcase
	end

	always_ff @(posedge CLK_n)
	begin
		if (!RST)
		begin
			cke        <= 1'b0;
			ready      <= 1'b0;
			pwr_cnt    <= '0;
			step_cnt   <= '0;
			stage      <= '0;
			settle_cnt <= '0;
			ini_cmd    <= NOOP;
		end
		else if (!cke)
		begin
			pwr_cnt <= pwr_cnt + 16'd1;
			if (pwr_cnt == 16'(POWER_UP_CYCLES - 1))
				cke <= 1'b1;
		end
		else if (!list_done)
		begin
			if (step_due)
			begin
				ini_cmd  <= rom_cmd;
				stage    <= stage + 3'd1;
				step_cnt <= '0;
			end
			else
			begin
				ini_cmd  <= NOOP;
				step_cnt <= step_cnt + 4'd1;
			end
		end
		else if (!ready)
		begin
			ini_cmd    <= NOOP;
			settle_cnt <= settle_cnt + 8'd1;
			if (settle_cnt == 8'(SETTLE_CYCLES - 1))
				ready <= 1'b1;    // stays high until reset
		end
	end

	always_ff @(posedge CLK_n)
	begin
		if (cke && !list_done && step_due)
		begin
			ini_addr <= rom_addr;
			ini_bank <= rom_bank;
		end
	end

endmodule

/* command_sequencer.sv */
`timescale 1ns/1ps

module command_sequencer
	import sdram_cmd_pkg::*;
	import ctrl_cfg_pkg::*;
(
	input  logic  CLK_n,
	input  logic  RST,
	input  logic  ready,
	input  logic  empty,
	input  req_t  pop_data,
	output logic  pop,
	output cmd_t  seq_cmd,
	output addr_t seq_addr,
	output bank_t seq_bank
);

	typedef enum logic [2:0] {IDLE, ACT, RCD, ACC, TAC, PRE, TRP} state_t;

	state_t     state;
	logic [2:0] gap_cnt;
	logic       gap_done;
	logic       wr_q;
	col_t       col_q;
	bank_t      pop_bank;
	addr_t      pop_row;

	assign pop      = (state == IDLE) && ready && !empty;
	assign gap_done = (gap_cnt == '0);
	assign pop_bank = pop_data[BANK_LSB +: $bits(bank_t)];
	assign pop_row  = pop_data[ROW_LSB +: $bits(addr_t)];

	always_ff @(posedge CLK_n)
	begin
		if (!RST)
		begin
			state   <= IDLE;
			gap_cnt <= '0;
			seq_cmd <= NOOP;
		end
		else
		begin
			seq_cmd <= NOOP;    // every gap cycle
			case (state)
				IDLE:
					if (pop)
					begin
						state   <= ACT;
						seq_cmd <= ACTV;
					end
				ACT:
				begin
					state   <= RCD;
					gap_cnt <= 3'(T_RCD - 1);
				end
				RCD:
					if (gap_done)
					begin
						state   <= ACC;
						seq_cmd <= wr_q ? WRIT : READ;
					end
					else
						gap_cnt <= gap_cnt - 1'b1;
				ACC:
				begin
					state   <= TAC;
					gap_cnt <= 3'(T_ACC - 1);
				end
				TAC:
					if (gap_done)
					begin
						state   <= PRE;
						seq_cmd <= PRCH;
					end
					else
						gap_cnt <= gap_cnt - 1'b1;
				PRE:
				begin
					// IDLE supplies the last precharge gap cycle
					state   <= TRP;
					gap_cnt <= 3'(T_RP - 2);
				end
				TRP:
					if (gap_done)
						state <= IDLE;
					else
						gap_cnt <= gap_cnt - 1'b1;
				default:
					state <= IDLE;
			endcase
		end
	end

	// bank holds for the whole request
	always_ff @(posedge CLK_n)
	begin
		if (pop)
		begin
			wr_q     <= pop_data[$bits(req_t) - 1];
			col_q    <= pop_data[COL_LSB +: $bits(col_t)];
			seq_addr <= pop_row;
			seq_bank <= pop_bank;
		end
		else if (state == RCD && gap_done)
			seq_addr <= addr_t'(col_q);       // column low, no auto precharge
		else if (state == TAC && gap_done)
			seq_addr[PRCH_ALL_BIT] <= 1'b0;   // single bank only
	end

endmodule

/* request_fifo.sv */
`timescale 1ns/1ps

module request_fifo
	import ctrl_cfg_pkg::*;
(
	input  logic CLK_n,
	input  logic RST,
	input  logic push,
	input  req_t push_data,
	input  logic pop,
	output req_t pop_data,
	output logic full,
	output logic empty
);

	req_t               mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	logic               do_push;
	logic               do_pop;

	assign full     = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
	assign empty    = (count == '0);
	assign do_push  = push && !full;    // push on full is dropped
	assign do_pop   = pop && !empty;
	assign pop_data = mem[rd_ptr];      // first word falls through

	always_ff @(posedge CLK_n)
	begin
		if (!RST)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;    // depth is a power of two, wraps
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge CLK_n)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

endmodule

/* request_framer.sv */
`timescale 1ns/1ps

module request_framer
	import sdram_cmd_pkg::*;
	import ctrl_cfg_pkg::*;
(
	input  logic      CLK_n,
	input  logic      RST,
	input  logic      req_rd,
	input  logic      req_wr,
	input  req_addr_t req_addr,
	output logic      push,
	output req_t      push_data
);

	bank_t bank;
	addr_t row;
	col_t  col;
	logic  strobe;

	assign bank   = req_addr[BANK_LSB +: $bits(bank_t)];
	assign row    = req_addr[ROW_LSB +: $bits(addr_t)];
	assign col    = req_addr[COL_LSB +: $bits(col_t)];
	assign strobe = req_rd | req_wr;

	always_ff @(posedge CLK_n)
	begin
		if (!RST)
			push <= 1'b0;
		else
			push <= strobe;
	end

	// rd and wr together end up as one write
	always_ff @(posedge CLK_n)
	begin
		if (strobe)
			push_data <= {req_wr, bank, row, col};
	end

endmodule

/* ctrl_cfg_pkg.sv */
package ctrl_cfg_pkg;

	import sdram_cmd_pkg::*;

	// power-up and init sequence
	localparam int POWER_UP_CYCLES = 65536;  // cke low, 16 bit count
	localparam int STEP_GAP        = 16;     // init command to init command
	localparam int SETTLE_CYCLES   = 256;    // last init command to ready

	// per request spacing, in noop cycles
	localparam int T_RCD = 2;                // activate to access
	localparam int T_ACC = 3;                // access to precharge
	localparam int T_RP  = 2;                // precharge to next activate

	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_AW    = 2;

	typedef logic [$bits(req_addr_t):0] req_t;  // write flag on top

endpackage

/* sdram_cmd_pkg.sv */
package sdram_cmd_pkg;

	typedef logic [2:0]  cmd_t;        // ras, cas, we
	typedef logic [12:0] addr_t;       // row / mode address pins
	typedef logic [1:0]  bank_t;
	typedef logic [8:0]  col_t;
	typedef logic [23:0] req_addr_t;   // bank on top, then row, then column

	// all pins active low, so NOOP is everything high
	localparam cmd_t NOOP = 3'b111;
	localparam cmd_t ACTV = 3'b011;
	localparam cmd_t READ = 3'b101;
	localparam cmd_t WRIT = 3'b100;
	localparam cmd_t PRCH = 3'b010;    // a10 high means all banks
	localparam cmd_t ARSR = 3'b001;
	localparam cmd_t MRST = 3'b000;

	localparam int PRCH_ALL_BIT = 10;

	// field positions inside req_addr_t
	localparam int COL_LSB  = 0;
	localparam int ROW_LSB  = COL_LSB + $bits(col_t);
	localparam int BANK_LSB = ROW_LSB + $bits(addr_t);

endpackage
